/* port_frontend_defines.svh */
`ifndef PORT_FRONTEND_DEFINES_SVH
`define PORT_FRONTEND_DEFINES_SVH

// packet data memory, in 16-bit words
`define PF_BUF_DEPTH   1024
// committed packets waiting for the scheduler
`define PF_DESC_DEPTH  4
// destinations 0 .. PF_NUM_PORTS-1 are valid
`define PF_NUM_PORTS   12

// header word layout
`define PF_LEN_MSB     15
`define PF_LEN_LSB     7
`define PF_PRIO_MSB    6
`define PF_PRIO_LSB    4
`define PF_PORT_MSB    3
`define PF_PORT_LSB    0

`endif

/* port_frontend_pkg.sv */
`include "port_frontend_defines.svh"

package port_frontend_pkg;

    typedef logic [15:0] pf_word_t;

    // header fields
    typedef logic [`PF_LEN_MSB-`PF_LEN_LSB:0]   pf_len_t;
    typedef logic [`PF_PRIO_MSB-`PF_PRIO_LSB:0] pf_prio_t;
    typedef logic [`PF_PORT_MSB-`PF_PORT_LSB:0] pf_port_t;

    // buffer addressing, space needs one extra bit to hold a full count
    typedef logic [$clog2(`PF_BUF_DEPTH)-1:0] pf_addr_t;
    typedef logic [$clog2(`PF_BUF_DEPTH):0]   pf_space_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_HDR,
        RX_DATA,
        RX_DISCARD
    } pf_rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_REQ,
        TX_WAIT_ACK_LOW,
        TX_STREAM
    } pf_tx_state_t;

endpackage

/* buf_wr_if.sv */
interface buf_wr_if import port_frontend_pkg::*; ();

    logic      wr_en;
    pf_word_t  wr_data;
    logic      commit;
    logic      discard;
    pf_port_t  desc_port;
    pf_len_t   desc_len;
    pf_prio_t  desc_prio;
    // status back from the buffer
    pf_space_t free_space;
    logic      desc_full;

    modport ctrl (
        output wr_en, wr_data, commit, discard, desc_port, desc_len, desc_prio,
        input  desc_full
    );

    modport buffer (
        input  wr_en, wr_data, commit, discard, desc_port, desc_len, desc_prio,
        output free_space, desc_full
    );

endinterface

/* buf_rd_if.sv */
interface buf_rd_if import port_frontend_pkg::*; ();

    // head descriptor and word at the read pointer
    logic      desc_vld;
    pf_len_t   head_len;
    pf_port_t  head_port;
    pf_prio_t  head_prio;
    pf_word_t  rd_data;

    // advance read pointer, release head descriptor
    logic      rd_en;
    logic      desc_pop;

    modport ctrl (
        input  desc_vld, head_len,
        output rd_en, desc_pop
    );

    modport buffer (
        output desc_vld, head_len, head_port, head_prio, rd_data,
        input  rd_en, desc_pop
    );

endinterface

/* word_counter.sv */
module word_counter import port_frontend_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    clear,
    input  logic    inc,
    input  pf_len_t limit,
    output pf_len_t count,
    output logic    at_limit
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else if (clear)
        begin
            count <= '0;
        end
        else if (inc)
        begin
            count <= count + 1'b1;
        end
    end

    assign at_limit = (count == limit);

    // the controller must stop counting once the programmed length is hit
    inc_below_limit: assert property (@(posedge clk) disable iff (!rst_n)
        !(inc && at_limit));

endmodule

/* header_parser.sv */
`include "port_frontend_defines.svh"

module header_parser import port_frontend_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      capture,
    input  pf_word_t  hdr,
    input  pf_space_t free_space,
    output pf_port_t  port,
    output pf_len_t   len,
    output pf_prio_t  prio,
    output logic      accept
);

    pf_port_t hdr_port;
    pf_len_t  hdr_len;
    pf_prio_t hdr_prio;

    assign hdr_len  = hdr[`PF_LEN_MSB:`PF_LEN_LSB];
    assign hdr_prio = hdr[`PF_PRIO_MSB:`PF_PRIO_LSB];
    assign hdr_port = hdr[`PF_PORT_MSB:`PF_PORT_LSB];

    // decided in the header cycle, space is reserved from here on
    assign accept = (hdr_port < `PF_NUM_PORTS) &&
                    (hdr_len != '0) &&
                    (pf_space_t'(hdr_len) <= free_space);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            port <= '0;
            len  <= '0;
            prio <= '0;
        end
        else if (capture)
        begin
            port <= hdr_port;
            len  <= hdr_len;
            prio <= hdr_prio;
        end
    end

endmodule

/* packet_buffer.sv */
`include "port_frontend_defines.svh"

module packet_buffer import port_frontend_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    buf_wr_if.buffer wr,
    buf_rd_if.buffer rd
);

    localparam int DESC_AW = $clog2(`PF_DESC_DEPTH);

    pf_word_t  mem [`PF_BUF_DEPTH];

    pf_addr_t  wr_ptr;
    pf_addr_t  start_ptr;
    pf_addr_t  rd_ptr;
    // committed words not yet read out
    pf_space_t used;

    pf_len_t   desc_len_q  [`PF_DESC_DEPTH];
    pf_port_t  desc_port_q [`PF_DESC_DEPTH];
    pf_prio_t  desc_prio_q [`PF_DESC_DEPTH];

    logic [DESC_AW-1:0] desc_wr_idx;
    logic [DESC_AW-1:0] desc_rd_idx;
    logic [DESC_AW:0]   desc_cnt;

    always_ff @(posedge clk)
    begin
        if (wr.wr_en)
        begin
            mem[wr_ptr] <= wr.wr_data;
        end
    end

    // write side, start_ptr marks the first word of the packet in progress
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr    <= '0;
            start_ptr <= '0;
        end
        else if (wr.discard)
        begin
            wr_ptr <= start_ptr;
        end
        else if (wr.commit)
        begin
            start_ptr <= wr_ptr;
        end
        else if (wr.wr_en)
        begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_ptr <= '0;
            used   <= '0;
        end
        else
        begin
            if (rd.rd_en)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            used <= used
                  + (wr.commit ? pf_space_t'(wr.desc_len) : pf_space_t'(0))
                  - (rd.rd_en  ? pf_space_t'(1)           : pf_space_t'(0));
        end
    end

    assign wr.free_space = pf_space_t'(`PF_BUF_DEPTH) - used;
    assign rd.rd_data    = mem[rd_ptr];

    // descriptor fields
    always_ff @(posedge clk)
    begin
        if (wr.commit)
        begin
            desc_len_q[desc_wr_idx]  <= wr.desc_len;
            desc_port_q[desc_wr_idx] <= wr.desc_port;
            desc_prio_q[desc_wr_idx] <= wr.desc_prio;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            desc_wr_idx <= '0;
            desc_rd_idx <= '0;
            desc_cnt    <= '0;
        end
        else
        begin
            if (wr.commit)
            begin
                desc_wr_idx <= desc_wr_idx + 1'b1;
            end
            if (rd.desc_pop)
            begin
                desc_rd_idx <= desc_rd_idx + 1'b1;
            end
            if (wr.commit && !rd.desc_pop)
            begin
                desc_cnt <= desc_cnt + 1'b1;
            end
            else if (!wr.commit && rd.desc_pop)
            begin
                desc_cnt <= desc_cnt - 1'b1;
            end
        end
    end

    assign wr.desc_full  = (desc_cnt == `PF_DESC_DEPTH);
    assign rd.desc_vld   = (desc_cnt != '0);
    assign rd.head_len   = desc_len_q[desc_rd_idx];
    assign rd.head_port  = desc_port_q[desc_rd_idx];
    assign rd.head_prio  = desc_prio_q[desc_rd_idx];

    // a packet ends either stored or rolled back, never both
    commit_xor_discard: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr.commit && wr.discard));

    // controller drops the packet at eop when no descriptor slot is left
    no_commit_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        wr.commit |-> !wr.desc_full);

endmodule

/* port_frontend_ctrl.sv */
module port_frontend_ctrl import port_frontend_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_sop,
    input  logic       wr_eop,
    input  logic       wr_vld,
    input  pf_word_t   wr_data,
    input  logic       pkt_ack,
    output logic       new_packet_into_buf,
    output logic       data_vld,
    output logic [7:0] drop_cnt,
    buf_wr_if.ctrl     wr,
    buf_rd_if.ctrl     rd,
    // header parser
    output logic       hdr_capture,
    input  logic       hdr_accept,
    input  pf_port_t   hdr_port,
    input  pf_len_t    hdr_len,
    input  pf_prio_t   hdr_prio,
    // word counters
    output logic       rx_clear,
    output logic       rx_inc,
    input  logic       rx_at_limit,
    output logic       tx_clear,
    output logic       tx_inc,
    output pf_len_t    tx_limit,
    input  logic       tx_at_limit
);

    pf_rx_state_t rx_state;
    pf_rx_state_t rx_next;
    pf_tx_state_t tx_state;
    pf_tx_state_t tx_next;
    logic         rx_drop;

    assign wr.wr_data   = wr_data;
    assign wr.desc_port = hdr_port;
    assign wr.desc_len  = hdr_len;
    assign wr.desc_prio = hdr_prio;

    always_comb
    begin
        rx_next     = rx_state;
        hdr_capture = 1'b0;
        rx_clear    = 1'b0;
        rx_inc      = 1'b0;
        rx_drop     = 1'b0;
        wr.wr_en    = 1'b0;
        wr.commit   = 1'b0;
        wr.discard  = 1'b0;
        case (rx_state)
            RX_IDLE:
            begin
                if (wr_sop)
                begin
                    rx_next = RX_HDR;
                end
            end
            RX_HDR:
            begin
                if (wr_vld)
                begin
                    hdr_capture = 1'b1;
                    rx_clear    = 1'b1;
                    if (hdr_accept)
                    begin
                        rx_next = RX_DATA;
                    end
                    else
                    begin
                        rx_drop = 1'b1;
                        rx_next = RX_DISCARD;
                    end
                end
            end
            RX_DATA:
            begin
                if (wr_eop)
                begin
                    rx_next = RX_IDLE;
                    // short packet or no descriptor slot
                    if (rx_at_limit && !wr.desc_full)
                    begin
                        wr.commit = 1'b1;
                    end
                    else
                    begin
                        wr.discard = 1'b1;
                        rx_drop    = 1'b1;
                    end
                end
                else if (wr_vld)
                begin
                    if (rx_at_limit)
                    begin
                        // one word too many, wait for eop
                        wr.discard = 1'b1;
                        rx_drop    = 1'b1;
                        rx_next    = RX_DISCARD;
                    end
                    else
                    begin
                        wr.wr_en = 1'b1;
                        rx_inc   = 1'b1;
                    end
                end
            end
            RX_DISCARD:
            begin
                if (wr_eop)
                begin
                    rx_next = RX_IDLE;
                end
            end
            default:
            begin
                rx_next = RX_IDLE;
            end
        endcase
    end

    always_comb
    begin
        tx_next     = tx_state;
        tx_clear    = 1'b0;
        tx_inc      = 1'b0;
        rd.rd_en    = 1'b0;
        rd.desc_pop = 1'b0;
        case (tx_state)
            TX_IDLE:
            begin
                if (rd.desc_vld && !pkt_ack)
                begin
                    tx_next = TX_REQ;
                end
            end
            TX_REQ:
            begin
                if (pkt_ack)
                begin
                    tx_next = TX_WAIT_ACK_LOW;
                end
            end
            TX_WAIT_ACK_LOW:
            begin
                if (!pkt_ack)
                begin
                    tx_clear = 1'b1;
                    tx_next  = TX_STREAM;
                end
            end
            TX_STREAM:
            begin
                rd.rd_en = 1'b1;
                if (tx_at_limit)
                begin
                    rd.desc_pop = 1'b1;
                    tx_next     = TX_IDLE;
                end
                else
                begin
                    tx_inc = 1'b1;
                end
            end
            default:
            begin
                tx_next = TX_IDLE;
            end
        endcase
    end

    // limit hits on the last word
    assign tx_limit = rd.head_len - 1'b1;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rx_state <= RX_IDLE;
            tx_state <= TX_IDLE;
            drop_cnt <= '0;
        end
        else
        begin
            rx_state <= rx_next;
            tx_state <= tx_next;
            if (rx_drop)
            begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    assign new_packet_into_buf = (tx_state == TX_REQ);
    assign data_vld            = (tx_state == TX_STREAM);

    // four-phase rule, the scheduler must have released ack first
    req_rise_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(new_packet_into_buf) |-> $past(!pkt_ack));

endmodule

/* port_frontend.sv */
module port_frontend import port_frontend_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_sop,
    input  logic       wr_eop,
    input  logic       wr_vld,
    input  pf_word_t   wr_data,
    input  logic       pkt_ack,
    output pf_port_t   dest_port,
    output pf_word_t   data,
    output logic       data_vld,
    output pf_len_t    length,
    output pf_prio_t   prio,
    output logic       new_packet_into_buf,
    output logic [7:0] drop_cnt
);

    buf_wr_if wr_if ();
    buf_rd_if rd_if ();

    logic     hdr_capture;
    logic     hdr_accept;
    pf_port_t hdr_port;
    pf_len_t  hdr_len;
    pf_prio_t hdr_prio;

    logic     rx_clear;
    logic     rx_inc;
    logic     rx_at_limit;
    logic     tx_clear;
    logic     tx_inc;
    pf_len_t  tx_limit;
    logic     tx_at_limit;

    port_frontend_ctrl i_ctrl (
        .clk                 (clk),
        .rst_n               (rst_n),
        .wr_sop              (wr_sop),
        .wr_eop              (wr_eop),
        .wr_vld              (wr_vld),
        .wr_data             (wr_data),
        .pkt_ack             (pkt_ack),
        .new_packet_into_buf (new_packet_into_buf),
        .data_vld            (data_vld),
        .drop_cnt            (drop_cnt),
        .wr                  (wr_if.ctrl),
        .rd                  (rd_if.ctrl),
        .hdr_capture         (hdr_capture),
        .hdr_accept          (hdr_accept),
        .hdr_port            (hdr_port),
        .hdr_len             (hdr_len),
        .hdr_prio            (hdr_prio),
        .rx_clear            (rx_clear),
        .rx_inc              (rx_inc),
        .rx_at_limit         (rx_at_limit),
        .tx_clear            (tx_clear),
        .tx_inc              (tx_inc),
        .tx_limit            (tx_limit),
        .tx_at_limit         (tx_at_limit)
    );

    header_parser i_parser (
        .clk        (clk),
        .rst_n      (rst_n),
        .capture    (hdr_capture),
        .hdr        (wr_data),
        .free_space (wr_if.free_space),
        .port       (hdr_port),
        .len        (hdr_len),
        .prio       (hdr_prio),
        .accept     (hdr_accept)
    );

    packet_buffer i_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr_if.buffer),
        .rd    (rd_if.buffer)
    );

    // received words against the header length
    word_counter rx_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (rx_clear),
        .inc      (rx_inc),
        .limit    (hdr_len),
        .count    (),
        .at_limit (rx_at_limit)
    );

    word_counter tx_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (tx_clear),
        .inc      (tx_inc),
        .limit    (tx_limit),
        .count    (),
        .at_limit (tx_at_limit)
    );

    assign dest_port = rd_if.head_port;
    assign length    = rd_if.head_len;
    assign prio      = rd_if.head_prio;
    assign data      = rd_if.rd_data;

endmodule

/* tb_port_frontend.sv */
`include "port_frontend_defines.svh"

module tb_port_frontend import port_frontend_pkg::*; ();

    logic       clk = 1'b0;
    logic       rst_n;
    logic       wr_sop;
    logic       wr_eop;
    logic       wr_vld;
    pf_word_t   wr_data;
    logic       pkt_ack;
    pf_port_t   dest_port;
    pf_word_t   data;
    logic       data_vld;
    pf_len_t    length;
    pf_prio_t   prio;
    logic       new_packet_into_buf;
    logic [7:0] drop_cnt;

    // stimulus table with one entry per packet
    int t_len[$];
    int t_port[$];
    int t_prio[$];
    int t_gap_start[$];
    int t_gap_len[$];
    int t_eop_off[$];
    int t_ack_delay[$];

    // reference queue with the oldest stored packet first
    int       exp_row[$];
    int       exp_len[$];
    int       exp_port[$];
    int       exp_prio[$];
    int       exp_delay[$];
    pf_word_t exp_words[$];

    int errors = 0;
    int delivered = 0;
    int dropped = 0;
    int exp_drops = 0;
    // predicted buffer occupancy
    int stored_cnt = 0;
    int done_cnt = 0;
    int committed_words = 0;
    int read_words = 0;
    int cycle_cnt = 0;
    int cycle_limit = 0;

    logic [31:0] lcg_state = 32'h6adc5bfa;
    logic        req_prev = 1'b0;
    logic        ack_prev = 1'b0;

    always #4 clk = ~clk;

    port_frontend i_port_frontend (
        .clk                 (clk),
        .rst_n               (rst_n),
        .wr_sop              (wr_sop),
        .wr_eop              (wr_eop),
        .wr_vld              (wr_vld),
        .wr_data             (wr_data),
        .pkt_ack             (pkt_ack),
        .dest_port           (dest_port),
        .data                (data),
        .data_vld            (data_vld),
        .length              (length),
        .prio                (prio),
        .new_packet_into_buf (new_packet_into_buf),
        .drop_cnt            (drop_cnt)
    );

    function automatic pf_word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    task automatic add_row(input int len, input int port, input int prio_v, input int gap_start,
                           input int gap_len, input int eop_off, input int ack_delay);
        t_len.push_back(len);
        t_port.push_back(port);
        t_prio.push_back(prio_v);
        t_gap_start.push_back(gap_start);
        t_gap_len.push_back(gap_len);
        t_eop_off.push_back(eop_off);
        t_ack_delay.push_back(ack_delay);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("mismatch at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("rows %0d, delivered %0d, dropped %0d, errors %0d",
                 t_len.size(), delivered, dropped, errors);
        if (errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic send_packet(input int r);
        pf_word_t hdr;
        pf_word_t word;
        pf_word_t words[$];
        int       nwords;
        int       free_words;
        bit       hdr_ok;
        bit       stored;
        hdr = '0;
        hdr[`PF_LEN_MSB:`PF_LEN_LSB]   = pf_len_t'(t_len[r]);
        hdr[`PF_PRIO_MSB:`PF_PRIO_LSB] = pf_prio_t'(t_prio[r]);
        hdr[`PF_PORT_MSB:`PF_PORT_LSB] = pf_port_t'(t_port[r]);
        nwords = t_len[r] + t_eop_off[r];
        @(posedge clk);
        wr_sop <= 1'b1;
        @(posedge clk);
        wr_sop  <= 1'b0;
        wr_vld  <= 1'b1;
        wr_data <= hdr;
        // stored words not yet read out hold their space
        free_words = `PF_BUF_DEPTH - (committed_words - read_words);
        hdr_ok = (t_port[r] < `PF_NUM_PORTS) && (t_len[r] != 0) && (t_len[r] <= free_words);
        for (int i = 0; i < nwords; i++)
        begin
            if (i == t_gap_start[r])
            begin
                repeat (t_gap_len[r])
                begin
                    @(posedge clk);
                    wr_vld <= 1'b0;
                end
            end
            word = lcg_next();
            @(posedge clk);
            wr_vld  <= 1'b1;
            wr_data <= word;
            words.push_back(word);
        end
        @(posedge clk);
        wr_vld <= 1'b0;
        wr_eop <= 1'b1;
        stored = hdr_ok && (t_eop_off[r] == 0) && (stored_cnt - done_cnt < `PF_DESC_DEPTH);
        if (stored)
        begin
            exp_row.push_back(r);
            exp_len.push_back(t_len[r]);
            exp_port.push_back(t_port[r]);
            exp_prio.push_back(t_prio[r]);
            exp_delay.push_back(t_ack_delay[r]);
            foreach (words[i])
            begin
                exp_words.push_back(words[i]);
            end
            committed_words += t_len[r];
            stored_cnt++;
        end
        else
        begin
            exp_drops++;
            dropped++;
        end
        @(posedge clk);
        wr_eop <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value(drop_cnt, exp_drops % 256, $sformatf("drop count after row %0d", r));
        if (!stored)
        begin
            $display("row %0d: dropped, drop_cnt %0d", r, drop_cnt);
        end
    endtask

    // scheduler model that answers each request and checks the streamed words
    initial
    begin : scheduler
        int       len;
        int       waited;
        pf_word_t want;
        pkt_ack = 1'b0;
        wait (rst_n === 1'b1);
        forever
        begin
            @(negedge clk);
            if (new_packet_into_buf)
            begin
                if (exp_len.size() == 0)
                begin
                    $display("request at time %0t for a packet that should have been dropped",
                             $time);
                    errors++;
                    wait (new_packet_into_buf == 1'b0);
                end
                else
                begin
                    len = exp_len[0];
                    check_value(dest_port, exp_port[0], "destination at request");
                    check_value(length, len, "length at request");
                    check_value(prio, exp_prio[0], "priority at request");
                    repeat (exp_delay[0]) @(negedge clk);
                    @(posedge clk);
                    pkt_ack <= 1'b1;
                    @(negedge clk);
                    check_value(new_packet_into_buf, 1, "request held until ack is sampled");
                    check_value(dest_port, exp_port[0], "destination held during request");
                    check_value(length, len, "length held during request");
                    check_value(prio, exp_prio[0], "priority held during request");
                    @(negedge clk);
                    check_value(new_packet_into_buf, 0, "request low one cycle after ack");
                    // ack may stay high a few cycles after req falls
                    repeat (exp_row[0] % 3)
                    begin
                        @(negedge clk);
                        check_value(data_vld, 0, "no data while ack is high");
                    end
                    @(posedge clk);
                    pkt_ack <= 1'b0;
                    waited = 0;
                    @(negedge clk);
                    while (!data_vld && waited < 4)
                    begin
                        waited++;
                        @(negedge clk);
                    end
                    if (!data_vld)
                    begin
                        $display("no data at time %0t after the handshake for row %0d",
                                 $time, exp_row[0]);
                        errors++;
                    end
                    else
                    begin
                        check_value(waited, 1, "cycles from ack low to first data word");
                        for (int i = 0; i < len; i++)
                        begin
                            want = exp_words.pop_front();
                            check_value(data_vld, 1, "data_vld held for the whole packet");
                            check_value(data, want, $sformatf("row %0d word %0d", exp_row[0], i));
                            read_words++;
                            if (i < len - 1)
                            begin
                                @(negedge clk);
                            end
                        end
                        done_cnt++;
                        @(negedge clk);
                        check_value(data_vld, 0, "data_vld low after the last word");
                        delivered++;
                        $display("row %0d: %0d words delivered to port %0d",
                                 exp_row[0], len, exp_port[0]);
                    end
                    void'(exp_row.pop_front());
                    void'(exp_len.pop_front());
                    void'(exp_port.pop_front());
                    void'(exp_prio.pop_front());
                    void'(exp_delay.pop_front());
                end
            end
        end
    end

    // four-phase rule on every exchange
    always @(negedge clk)
    begin
        if (rst_n && new_packet_into_buf && !req_prev)
        begin
            check_value(ack_prev, 0, "ack low when request rises");
        end
        req_prev = new_packet_into_buf;
        ack_prev = pkt_ack;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            errors++;
            finish_run();
        end
    end

    initial
    begin
        int limit;
        rst_n   = 1'b0;
        wr_sop  = 1'b0;
        wr_eop  = 1'b0;
        wr_vld  = 1'b0;
        wr_data = '0;
        // len, dest, prio, gap start, gap len, eop offset, ack delay
        add_row(8, 3, 5, 3, 2, 0, 2);
        add_row(5, 12, 1, 0, 0, 0, 1);
        add_row(0, 4, 2, 0, 0, 0, 1);
        add_row(6, 15, 7, 0, 0, 0, 1);
        add_row(7, 2, 3, 2, 1, -1, 1);
        add_row(7, 2, 3, 0, 0, 1, 1);
        add_row(12, 0, 6, 5, 3, 0, 4);
        // long ack delay fills the descriptor queue
        add_row(4, 1, 0, 0, 0, 0, 60);
        add_row(3, 5, 1, 1, 1, 0, 2);
        add_row(3, 6, 2, 0, 0, 0, 2);
        add_row(3, 7, 3, 0, 0, 0, 2);
        add_row(3, 8, 4, 0, 0, 0, 2);
        add_row(3, 9, 5, 0, 0, 0, 2);
        // buffer space runs out
        add_row(500, 9, 4, 100, 5, 0, 600);
        add_row(500, 10, 2, 0, 0, 0, 1);
        add_row(40, 11, 1, 0, 0, 0, 1);
        add_row(20, 4, 6, 7, 2, 0, 3);
        add_row(4, 11, 7, 0, 0, 0, 0);
        limit = 0;
        foreach (t_len[i])
        begin
            limit += t_len[i] + t_gap_len[i] + t_ack_delay[i] + 20;
        end
        cycle_limit = 2 * limit;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value(new_packet_into_buf, 0, "request after reset");
        check_value(data_vld, 0, "data_vld after reset");
        check_value(drop_cnt, 0, "drop count after reset");
        for (int r = 0; r < t_len.size(); r++)
        begin
            send_packet(r);
        end
        while (exp_len.size() != 0)
        begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_value(drop_cnt, exp_drops % 256, "final drop count");
        finish_run();
    end

endmodule

/* port_frontend.f */
+incdir+.
port_frontend_pkg.sv
buf_wr_if.sv
buf_rd_if.sv
word_counter.sv
header_parser.sv
packet_buffer.sv
port_frontend_ctrl.sv
port_frontend.sv
tb_port_frontend.sv
